// File: flist.f
source/sd_host_pkg.sv
source/sd_cmd_if.sv
source/sd_host_regs.sv
source/sd_clock_divider.sv
source/sd_cmd_master.sv
source/sd_cmd_serial_host.sv
source/sd_host_top.sv
sim/sd_card_model.sv
sim/tb_sd_host.sv

// File: Makefile
SIM_BIN := obj_dir/tb_sd_host

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_sd_host -f flist.f -o tb_sd_host

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: sim/tb_sd_host.sv
`timescale 1ns/100ps

module tb_sd_host;

    // 9 commands, each up to 2 x 48 sd bits at 2 x (4+1) cycles,
    // plus response timeout waits, polling and margin
    localparam int MAX_CYCLES = 20000;

    logic wb_clk_i;
    logic rst_i;
    logic [sd_host_pkg::WB_ADDR_W-1:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic wb_we_i;
    logic wb_stb_i;
    logic wb_cyc_i;
    logic wb_ack_o;
    logic sd_clk_o;
    logic sd_cmd_o;
    logic sd_cmd_oe_o;
    logic sd_cmd_i;
    logic interrupt_o;

    // what the card should see
    logic [sd_host_pkg::CMD_INDEX_W-1:0] exp_index;
    logic [sd_host_pkg::ARG_W-1:0] exp_argument;
    logic [sd_host_pkg::DIVISOR_W-1:0] exp_divisor;
    logic [sd_host_pkg::INT_W-1:0] enable;
    int frame_count;
    logic [sd_host_pkg::CMD_INDEX_W-1:0] last_index;
    int card_errors;
    int errors = 0;
    int cycles = 0;
    logic [31:0] rng_state;

    sd_host_top u_sd_host_top (
        .wb_clk_i    (wb_clk_i),
        .rst_i       (rst_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_we_i     (wb_we_i),
        .wb_stb_i    (wb_stb_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_ack_o    (wb_ack_o),
        .sd_clk_o    (sd_clk_o),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o),
        .sd_cmd_i    (sd_cmd_i),
        .interrupt_o (interrupt_o)
    );

    sd_card_model u_sd_card_model (
        .clk_i          (wb_clk_i),
        .sd_clk_i       (sd_clk_o),
        .cmd_i          (sd_cmd_o),
        .cmd_oe_i       (sd_cmd_oe_o),
        .cmd_o          (sd_cmd_i),
        .exp_index_i    (exp_index),
        .exp_argument_i (exp_argument),
        .exp_divisor_i  (exp_divisor),
        .frame_count_o  (frame_count),
        .last_index_o   (last_index),
        .error_count_o  (card_errors)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    always @(posedge wb_clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a command never completed", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // complete is always set, error bits as given
    function automatic logic [sd_host_pkg::INT_W-1:0] status_of(input logic timeout,
            input logic crc_err, input logic index_err);
        logic [sd_host_pkg::INT_W-1:0] s;
        s = '0;
        s[sd_host_pkg::INT_CMD_COMPLETE] = 1'b1;
        s[sd_host_pkg::INT_CMD_TIMEOUT] = timeout;
        s[sd_host_pkg::INT_CMD_CRC_ERR] = crc_err;
        s[sd_host_pkg::INT_CMD_INDEX_ERR] = index_err;
        return s;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [2:0] addr, input logic [31:0] data);
        @(posedge wb_clk_i);
        wb_adr_i <= addr;
        wb_dat_i <= data;
        wb_we_i <= 1'b1;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        @(posedge wb_clk_i);
        while (!wb_ack_o) begin
            @(posedge wb_clk_i);
        end
        wb_we_i <= 1'b0;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] addr, output logic [31:0] data);
        @(posedge wb_clk_i);
        wb_adr_i <= addr;
        wb_we_i <= 1'b0;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        @(posedge wb_clk_i);
        while (!wb_ack_o) begin
            @(posedge wb_clk_i);
        end
        data = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    // poll present state until command inhibit drops
    task automatic wait_inhibit_clear();
        logic [31:0] state;
        state = 32'd1;
        while (state[0]) begin
            wb_read(sd_host_pkg::REG_PRESENT_STATE, state);
        end
    endtask

    task automatic check_status(input logic [sd_host_pkg::INT_W-1:0] exp_status);
        logic [31:0] data;
        wb_read(sd_host_pkg::REG_INT_STATUS, data);
        expect_equal("REG_INT_STATUS", 32'(exp_status), data);
        expect_equal("interrupt_o", 32'(|(exp_status & enable)), 32'(interrupt_o));
        wb_write(sd_host_pkg::REG_INT_STATUS, 32'hf);
        wb_read(sd_host_pkg::REG_INT_STATUS, data);
        expect_equal("REG_INT_STATUS after clear", 32'd0, data);
        expect_equal("interrupt_o after clear", 32'd0, 32'(interrupt_o));
    endtask

    task automatic run_command(input logic [5:0] index, input sd_host_pkg::sd_resp_e resp,
                               input logic [sd_host_pkg::INT_W-1:0] exp_status);
        logic [31:0] arg;
        logic [31:0] data;
        int frames_before;
        arg = xorshift32();
        frames_before = frame_count;
        exp_index = index;
        exp_argument = arg;
        wb_write(sd_host_pkg::REG_ARGUMENT, arg);
        wb_write(sd_host_pkg::REG_COMMAND, {24'd0, resp, index});
        wait_inhibit_clear();
        expect_equal("card frame count", frames_before + 1, frame_count);
        expect_equal("card last index", 32'(index), 32'(last_index));
        if (exp_status == status_of(1'b0, 1'b0, 1'b0) && resp == sd_host_pkg::RESP_SHORT) begin
            wb_read(sd_host_pkg::REG_RESPONSE, data);
            expect_equal("REG_RESPONSE", ~arg, data);
        end
        check_status(exp_status);
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] arg;
        int frames_before;
        rst_i <= 1'b1;
        wb_adr_i <= '0;
        wb_dat_i <= '0;
        wb_we_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_cyc_i <= 1'b0;
        exp_index = '0;
        exp_argument = '0;
        exp_divisor = sd_host_pkg::DIVISOR_RESET;
        enable = '0;
        rng_state = 32'd25227;
        repeat (8) @(posedge wb_clk_i);
        rst_i <= 1'b0;
        @(posedge wb_clk_i);

        // idle outputs after reset
        expect_equal("sd_cmd_oe_o", 32'd0, 32'(sd_cmd_oe_o));
        expect_equal("sd_cmd_o", 32'd1, 32'(sd_cmd_o));
        expect_equal("interrupt_o", 32'd0, 32'(interrupt_o));
        wb_read(sd_host_pkg::REG_INT_STATUS, data);
        expect_equal("REG_INT_STATUS", 32'd0, data);
        wb_read(sd_host_pkg::REG_DIVISOR, data);
        expect_equal("REG_DIVISOR", 32'(sd_host_pkg::DIVISOR_RESET), data);

        // short responses at the reset divisor
        run_command(6'd17, sd_host_pkg::RESP_SHORT, status_of(1'b0, 1'b0, 1'b0));
        run_command(6'd2, sd_host_pkg::RESP_SHORT, status_of(1'b0, 1'b0, 1'b0));
        run_command(6'd55, sd_host_pkg::RESP_SHORT, status_of(1'b0, 1'b0, 1'b0));

        // faster sd clock
        exp_divisor = 8'd1;
        wb_write(sd_host_pkg::REG_DIVISOR, 32'd1);
        run_command(6'd8, sd_host_pkg::RESP_SHORT, status_of(1'b0, 1'b0, 1'b0));

        // error cases, interrupt on error bits only
        enable = 4'b1110;
        wb_write(sd_host_pkg::REG_INT_ENABLE, {28'd0, enable});
        run_command(6'd5, sd_host_pkg::RESP_SHORT, status_of(1'b1, 1'b0, 1'b0));
        run_command(6'd13, sd_host_pkg::RESP_SHORT, status_of(1'b0, 1'b1, 1'b0));
        run_command(6'd7, sd_host_pkg::RESP_SHORT, status_of(1'b0, 1'b0, 1'b1));

        // no response expected, so no timeout either
        enable = 4'b0001;
        wb_write(sd_host_pkg::REG_INT_ENABLE, {28'd0, enable});
        run_command(6'd5, sd_host_pkg::RESP_NONE, status_of(1'b0, 1'b0, 1'b0));

        // second command while inhibit is set must be dropped
        arg = xorshift32();
        frames_before = frame_count;
        exp_index = 6'd9;
        exp_argument = arg;
        wb_write(sd_host_pkg::REG_ARGUMENT, arg);
        wb_write(sd_host_pkg::REG_COMMAND, {24'd0, sd_host_pkg::RESP_SHORT, 6'd9});
        wb_read(sd_host_pkg::REG_PRESENT_STATE, data);
        expect_equal("REG_PRESENT_STATE inhibit", 32'd1, 32'(data[0]));
        // a no-response type here would stop the response capture if it got through
        wb_write(sd_host_pkg::REG_COMMAND, {24'd0, sd_host_pkg::RESP_NONE, 6'd22});
        wait_inhibit_clear();
        repeat (200) @(posedge wb_clk_i);
        expect_equal("card frame count", frames_before + 1, frame_count);
        expect_equal("card last index", 32'd9, 32'(last_index));
        wb_read(sd_host_pkg::REG_RESPONSE, data);
        expect_equal("REG_RESPONSE", ~arg, data);
        check_status(status_of(1'b0, 1'b0, 1'b0));

        $display("errors: testbench %0d, card model %0d", errors, card_errors);
        if (errors == 0 && card_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sim/sd_card_model.sv
`timescale 1ns/100ps

module sd_card_model (
    input  logic                                 clk_i,
    input  logic                                 sd_clk_i,
    input  logic                                 cmd_i,
    input  logic                                 cmd_oe_i,
    output logic                                 cmd_o,
    input  logic [sd_host_pkg::CMD_INDEX_W-1:0]  exp_index_i,
    input  logic [sd_host_pkg::ARG_W-1:0]        exp_argument_i,
    input  logic [sd_host_pkg::DIVISOR_W-1:0]    exp_divisor_i,
    output int                                   frame_count_o,
    output logic [sd_host_pkg::CMD_INDEX_W-1:0]  last_index_o,
    output int                                   error_count_o
);

    logic sd_clk_q = 1'b0;
    logic drive = 1'b1;
    logic [47:0] rx_frame = '0;
    logic [47:0] tx_frame = '1;
    logic [5:0] last_index = '0;
    int rx_bits = 0;
    int tx_bits = 0;
    int tx_delay = 0;
    int period = 0;
    int frames = 0;
    int errors = 0;

    assign cmd_o = drive;
    assign frame_count_o = frames;
    assign last_index_o = last_index;
    assign error_count_o = errors;

    // x^7 + x^3 + 1, msb first
    function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic din);
        logic fb;
        fb = crc[6] ^ din;
        return {crc[5:0], fb} ^ {3'b000, fb, 3'b000};
    endfunction

    function automatic logic [6:0] crc7_over(input logic [47:0] frame);
        logic [6:0] crc;
        crc = 7'd0;
        for (int i = 47; i >= 8; i--) begin
            crc = crc7_step(crc, frame[i]);
        end
        return crc;
    endfunction

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("ERROR %0t card %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // check a received command and line up the answer
    task automatic take_frame();
        logic [5:0] idx;
        logic [5:0] resp_idx;
        logic [6:0] crc;
        logic [47:0] resp;
        idx = rx_frame[45:40];
        check_field("start bit", 32'd0, 32'(rx_frame[47]));
        check_field("transmit bit", 32'd1, 32'(rx_frame[46]));
        check_field("index", 32'(exp_index_i), 32'(idx));
        check_field("argument", exp_argument_i, rx_frame[39:8]);
        check_field("crc7", 32'(crc7_over(rx_frame)), 32'(rx_frame[7:1]));
        check_field("end bit", 32'd1, 32'(rx_frame[0]));
        frames++;
        last_index = idx;
        // index 5 never answers
        if (idx != 6'd5) begin
            resp_idx = (idx == 6'd7) ? 6'd8 : idx;
            resp = {1'b0, 1'b0, resp_idx, ~rx_frame[39:8], 7'd0, 1'b1};
            crc = crc7_over(resp);
            if (idx == 6'd13) begin
                crc = ~crc;
            end
            resp[7:1] = crc;
            tx_frame = resp;
            tx_bits = 48;
            tx_delay = 2;
        end
    endtask

    // runs off the system clock, sd_clk edges seen through sd_clk_q
    always @(posedge clk_i) begin
        period = period + 1;
        if (sd_clk_i && !sd_clk_q) begin
            if (cmd_oe_i) begin
                check_field("sd_clk_o period", 2 * (int'(exp_divisor_i) + 1), period);
                rx_frame = {rx_frame[46:0], cmd_i};
                rx_bits = rx_bits + 1;
                if (rx_bits == 48) begin
                    take_frame();
                    rx_bits = 0;
                end
            end
            period = 0;
        end
        if (!sd_clk_i && sd_clk_q) begin
            if (tx_bits == 0) begin
                drive <= 1'b1;
            end else if (tx_delay > 0) begin
                tx_delay = tx_delay - 1;
            end else begin
                drive <= tx_frame[47];
                tx_frame = tx_frame << 1;
                tx_bits = tx_bits - 1;
            end
        end
        sd_clk_q = sd_clk_i;
    end

endmodule

// File: source/sd_host_top.sv
`timescale 1ns/100ps

module sd_host_top (
    input  logic                              wb_clk_i,
    input  logic                              rst_i,
    input  logic [sd_host_pkg::WB_ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]                       wb_dat_i,
    output logic [31:0]                       wb_dat_o,
    input  logic                              wb_we_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_cyc_i,
    output logic                              wb_ack_o,
    output logic                              sd_clk_o,
    output logic                              sd_cmd_o,
    output logic                              sd_cmd_oe_o,
    input  logic                              sd_cmd_i,
    output logic                              interrupt_o
);

    logic [sd_host_pkg::DIVISOR_W-1:0] divisor;
    logic sd_clk_rise;

    // register file to command master
    logic cmd_start;
    logic [sd_host_pkg::CMD_INDEX_W-1:0] cmd_index;
    sd_host_pkg::sd_resp_e cmd_resp_type;
    logic [sd_host_pkg::ARG_W-1:0] cmd_argument;

    // command master back to register file
    logic cmd_busy;
    logic [sd_host_pkg::ARG_W-1:0] response;
    logic evt_complete;
    logic evt_timeout;
    logic evt_crc_err;
    logic evt_index_err;

    sd_cmd_if u_cmd_if ();

    sd_host_regs u_sd_host_regs (
        .wb_clk_i        (wb_clk_i),
        .rst_i           (rst_i),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .wb_dat_o        (wb_dat_o),
        .wb_we_i         (wb_we_i),
        .wb_stb_i        (wb_stb_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_ack_o        (wb_ack_o),
        .divisor_o       (divisor),
        .cmd_start_o     (cmd_start),
        .cmd_index_o     (cmd_index),
        .cmd_resp_type_o (cmd_resp_type),
        .cmd_argument_o  (cmd_argument),
        .cmd_busy_i      (cmd_busy),
        .response_i      (response),
        .evt_complete_i  (evt_complete),
        .evt_timeout_i   (evt_timeout),
        .evt_crc_err_i   (evt_crc_err),
        .evt_index_err_i (evt_index_err),
        .interrupt_o     (interrupt_o)
    );

    sd_clock_divider u_sd_clock_divider (
        .wb_clk_i      (wb_clk_i),
        .rst_i         (rst_i),
        .divisor_i     (divisor),
        .sd_clk_o      (sd_clk_o),
        .sd_clk_rise_o (sd_clk_rise)
    );

    sd_cmd_master u_sd_cmd_master (
        .wb_clk_i        (wb_clk_i),
        .rst_i           (rst_i),
        .start_i         (cmd_start),
        .index_i         (cmd_index),
        .resp_type_i     (cmd_resp_type),
        .argument_i      (cmd_argument),
        .busy_o          (cmd_busy),
        .response_o      (response),
        .evt_complete_o  (evt_complete),
        .evt_timeout_o   (evt_timeout),
        .evt_crc_err_o   (evt_crc_err),
        .evt_index_err_o (evt_index_err),
        .cmd             (u_cmd_if.master)
    );

    sd_cmd_serial_host u_sd_cmd_serial_host (
        .wb_clk_i      (wb_clk_i),
        .rst_i         (rst_i),
        .sd_clk_rise_i (sd_clk_rise),
        .sd_cmd_i      (sd_cmd_i),
        .sd_cmd_o      (sd_cmd_o),
        .sd_cmd_oe_o   (sd_cmd_oe_o),
        .cmd           (u_cmd_if.host)
    );

endmodule

// File: source/sd_cmd_serial_host.sv
`timescale 1ns/100ps

module sd_cmd_serial_host (
    input  logic    wb_clk_i,
    input  logic    rst_i,
    input  logic    sd_clk_rise_i,
    input  logic    sd_cmd_i,
    output logic    sd_cmd_o,
    output logic    sd_cmd_oe_o,
    sd_cmd_if.host  cmd
);

    typedef enum logic [2:0] {
        IDLE,
        SEND,
        WAIT_START,
        RECEIVE,
        FINISH
    } state_e;

    state_e state;
    logic [sd_host_pkg::CMD_FRAME_W-1:0] shift_q;
    logic [6:0] crc;
    logic [5:0] bit_cnt;
    logic [$clog2(sd_host_pkg::RESP_TIMEOUT_SD_CLKS)-1:0] timer;
    logic [sd_host_pkg::CMD_INDEX_W-1:0] index_q;
    sd_host_pkg::sd_resp_e resp_q;
    logic timed_out;
    logic rx_checked;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state <= IDLE;
            sd_cmd_o <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
            bit_cnt <= '0;
            timer <= '0;
            timed_out <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd.start) begin
                        // start bit, transmit bit, index, argument, room for crc and end
                        shift_q <= {1'b0, 1'b1, cmd.index, cmd.argument, 8'h00};
                        index_q <= cmd.index;
                        resp_q <= cmd.resp_type;
                        crc <= '0;
                        bit_cnt <= '0;
                        timed_out <= 1'b0;
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (sd_clk_rise_i) begin
                        if (int'(bit_cnt) == sd_host_pkg::CMD_FRAME_W) begin
                            // last bit has been seen by the card, release the line
                            sd_cmd_oe_o <= 1'b0;
                            sd_cmd_o <= 1'b1;
                            timer <= '0;
                            state <= (resp_q == sd_host_pkg::RESP_SHORT) ? WAIT_START : FINISH;
                        end else begin
                            sd_cmd_oe_o <= 1'b1;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (int'(bit_cnt) < sd_host_pkg::CMD_FRAME_W - 8) begin
                                sd_cmd_o <= shift_q[sd_host_pkg::CMD_FRAME_W-1];
                                shift_q <= shift_q << 1;
                                crc <= sd_host_pkg::crc7_next(
                                    crc, shift_q[sd_host_pkg::CMD_FRAME_W-1]);
                            end else if (int'(bit_cnt) < sd_host_pkg::CMD_FRAME_W - 1) begin
                                sd_cmd_o <= crc[6];
                                crc <= crc << 1;
                            end else begin
                                sd_cmd_o <= 1'b1;
                            end
                        end
                    end
                end
                WAIT_START: begin
                    if (sd_clk_rise_i) begin
                        if (!sd_cmd_i) begin
                            shift_q <= {shift_q[sd_host_pkg::CMD_FRAME_W-2:0], sd_cmd_i};
                            crc <= sd_host_pkg::crc7_next(7'd0, sd_cmd_i);
                            bit_cnt <= 6'd1;
                            state <= RECEIVE;
                        end else if (int'(timer) == sd_host_pkg::RESP_TIMEOUT_SD_CLKS - 1) begin
                            timed_out <= 1'b1;
                            state <= FINISH;
                        end else begin
                            timer <= timer + 1'b1;
                        end
                    end
                end
                RECEIVE: begin
                    if (sd_clk_rise_i) begin
                        shift_q <= {shift_q[sd_host_pkg::CMD_FRAME_W-2:0], sd_cmd_i};
                        // crc covers the first 40 bits only
                        if (int'(bit_cnt) < sd_host_pkg::CMD_FRAME_W - 8) begin
                            crc <= sd_host_pkg::crc7_next(crc, sd_cmd_i);
                        end
                        bit_cnt <= bit_cnt + 1'b1;
                        if (int'(bit_cnt) == sd_host_pkg::CMD_FRAME_W - 1) begin
                            state <= FINISH;
                        end
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // checks only apply to a short response that actually arrived
    assign rx_checked = (resp_q == sd_host_pkg::RESP_SHORT) && !timed_out;

    assign cmd.done = (state == FINISH);
    assign cmd.timeout = timed_out;
    assign cmd.response = shift_q[sd_host_pkg::CMD_FRAME_W-9 -: sd_host_pkg::ARG_W];
    assign cmd.crc_err = rx_checked && (shift_q[7:1] != crc);
    assign cmd.index_err = rx_checked &&
        (shift_q[sd_host_pkg::CMD_FRAME_W-3 -: sd_host_pkg::CMD_INDEX_W] != index_q);

endmodule

// File: source/sd_cmd_master.sv
`timescale 1ns/100ps

module sd_cmd_master (
    input  logic                                wb_clk_i,
    input  logic                                rst_i,
    input  logic                                start_i,
    input  logic [sd_host_pkg::CMD_INDEX_W-1:0] index_i,
    input  sd_host_pkg::sd_resp_e               resp_type_i,
    input  logic [sd_host_pkg::ARG_W-1:0]       argument_i,
    output logic                                busy_o,
    output logic [sd_host_pkg::ARG_W-1:0]       response_o,
    output logic                                evt_complete_o,
    output logic                                evt_timeout_o,
    output logic                                evt_crc_err_o,
    output logic                                evt_index_err_o,
    sd_cmd_if.master                            cmd
);

    logic accept;

    // starts while a command is in flight are dropped
    assign accept = start_i & ~busy_o;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            busy_o <= 1'b0;
            cmd.start <= 1'b0;
            evt_complete_o <= 1'b0;
            evt_timeout_o <= 1'b0;
            evt_crc_err_o <= 1'b0;
            evt_index_err_o <= 1'b0;
        end else begin
            cmd.start <= accept;
            evt_complete_o <= cmd.done;
            evt_timeout_o <= cmd.done & cmd.timeout;
            evt_crc_err_o <= cmd.done & cmd.crc_err;
            evt_index_err_o <= cmd.done & cmd.index_err;
            if (accept) begin
                busy_o <= 1'b1;
            end else if (cmd.done) begin
                busy_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            cmd.index <= index_i;
            cmd.resp_type <= resp_type_i;
            cmd.argument <= argument_i;
        end
        // keep the last good response on timeout or no-response commands
        if (cmd.done && !cmd.timeout && cmd.resp_type == sd_host_pkg::RESP_SHORT) begin
            response_o <= cmd.response;
        end
    end

endmodule

// File: source/sd_clock_divider.sv
`timescale 1ns/100ps

module sd_clock_divider (
    input  logic                              wb_clk_i,
    input  logic                              rst_i,
    input  logic [sd_host_pkg::DIVISOR_W-1:0] divisor_i,
    output logic                              sd_clk_o,
    output logic                              sd_clk_rise_o
);

    logic [sd_host_pkg::DIVISOR_W-1:0] count;
    logic toggle;

    // >= so a smaller divisor written mid-count takes effect at once
    assign toggle = count >= divisor_i;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            count <= '0;
            sd_clk_o <= 1'b0;
            sd_clk_rise_o <= 1'b0;
        end else begin
            // strobe lines up with the cycle in which sd_clk_o is first high
            sd_clk_rise_o <= toggle & ~sd_clk_o;
            if (toggle) begin
                count <= '0;
                sd_clk_o <= ~sd_clk_o;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: source/sd_host_regs.sv
`timescale 1ns/100ps

module sd_host_regs (
    input  logic                                 wb_clk_i,
    input  logic                                 rst_i,
    input  logic [sd_host_pkg::WB_ADDR_W-1:0]    wb_adr_i,
    input  logic [31:0]                          wb_dat_i,
    output logic [31:0]                          wb_dat_o,
    input  logic                                 wb_we_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_cyc_i,
    output logic                                 wb_ack_o,
    output logic [sd_host_pkg::DIVISOR_W-1:0]    divisor_o,
    output logic                                 cmd_start_o,
    output logic [sd_host_pkg::CMD_INDEX_W-1:0]  cmd_index_o,
    output sd_host_pkg::sd_resp_e                cmd_resp_type_o,
    output logic [sd_host_pkg::ARG_W-1:0]        cmd_argument_o,
    input  logic                                 cmd_busy_i,
    input  logic [sd_host_pkg::ARG_W-1:0]        response_i,
    input  logic                                 evt_complete_i,
    input  logic                                 evt_timeout_i,
    input  logic                                 evt_crc_err_i,
    input  logic                                 evt_index_err_i,
    output logic                                 interrupt_o
);

    sd_host_pkg::sd_reg_e addr;
    logic req;
    logic wr_en;
    logic [31:0] rd_data;
    logic [sd_host_pkg::INT_W-1:0] int_status;
    logic [sd_host_pkg::INT_W-1:0] int_enable;
    logic [sd_host_pkg::INT_W-1:0] int_events;
    logic [sd_host_pkg::INT_W-1:0] int_clear;

    assign addr = sd_host_pkg::sd_reg_e'(wb_adr_i);

    // one access per request, no wait states
    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr_en = req & wb_we_i;

    always_comb begin
        int_events = '0;
        int_events[sd_host_pkg::INT_CMD_COMPLETE] = evt_complete_i;
        int_events[sd_host_pkg::INT_CMD_TIMEOUT] = evt_timeout_i;
        int_events[sd_host_pkg::INT_CMD_CRC_ERR] = evt_crc_err_i;
        int_events[sd_host_pkg::INT_CMD_INDEX_ERR] = evt_index_err_i;
    end

    // write-one-to-clear
    assign int_clear = (wr_en && addr == sd_host_pkg::REG_INT_STATUS) ?
                       wb_dat_i[sd_host_pkg::INT_W-1:0] : '0;

    always_comb begin
        rd_data = '0;
        case (addr)
            sd_host_pkg::REG_ARGUMENT:      rd_data = cmd_argument_o;
            sd_host_pkg::REG_COMMAND:       rd_data[7:0] = {cmd_resp_type_o, cmd_index_o};
            sd_host_pkg::REG_RESPONSE:      rd_data = response_i;
            sd_host_pkg::REG_DIVISOR:       rd_data[sd_host_pkg::DIVISOR_W-1:0] = divisor_o;
            sd_host_pkg::REG_INT_STATUS:    rd_data[sd_host_pkg::INT_W-1:0] = int_status;
            sd_host_pkg::REG_INT_ENABLE:    rd_data[sd_host_pkg::INT_W-1:0] = int_enable;
            // bit 0 is command inhibit
            sd_host_pkg::REG_PRESENT_STATE: rd_data[0] = cmd_busy_i;
            default:                        rd_data = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
            cmd_start_o <= 1'b0;
            divisor_o <= sd_host_pkg::DIVISOR_RESET;
            int_status <= '0;
            int_enable <= '0;
        end else begin
            wb_ack_o <= req;
            cmd_start_o <= wr_en && addr == sd_host_pkg::REG_COMMAND;
            // a new event wins over a clear in the same cycle
            int_status <= (int_status & ~int_clear) | int_events;
            if (wr_en && addr == sd_host_pkg::REG_DIVISOR) begin
                divisor_o <= wb_dat_i[sd_host_pkg::DIVISOR_W-1:0];
            end
            if (wr_en && addr == sd_host_pkg::REG_INT_ENABLE) begin
                int_enable <= wb_dat_i[sd_host_pkg::INT_W-1:0];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            wb_dat_o <= rd_data;
        end
        if (wr_en && addr == sd_host_pkg::REG_ARGUMENT) begin
            cmd_argument_o <= wb_dat_i;
        end
        if (wr_en && addr == sd_host_pkg::REG_COMMAND) begin
            cmd_index_o <= wb_dat_i[sd_host_pkg::CMD_INDEX_W-1:0];
            cmd_resp_type_o <= sd_host_pkg::sd_resp_e'(
                wb_dat_i[sd_host_pkg::CMD_INDEX_W+1:sd_host_pkg::CMD_INDEX_W]);
        end
    end

    assign interrupt_o = |(int_status & int_enable);

endmodule

// File: source/sd_cmd_if.sv
`timescale 1ns/100ps

interface sd_cmd_if;

    // request, held stable by the master for the whole command
    logic start;
    logic [sd_host_pkg::CMD_INDEX_W-1:0] index;
    logic [sd_host_pkg::ARG_W-1:0] argument;
    sd_host_pkg::sd_resp_e resp_type;

    // result, flags valid while done is high
    logic done;
    logic [sd_host_pkg::ARG_W-1:0] response;
    logic timeout;
    logic crc_err;
    logic index_err;

    modport master (
        output start, index, argument, resp_type,
        input  done, response, timeout, crc_err, index_err
    );

    modport host (
        input  start, index, argument, resp_type,
        output done, response, timeout, crc_err, index_err
    );

endinterface

// File: source/sd_host_pkg.sv
package sd_host_pkg;

    // frame geometry
    localparam int CMD_FRAME_W = 48;
    localparam int ARG_W = 32;
    localparam int CMD_INDEX_W = 6;

    // clocking and response wait
    localparam int DIVISOR_W = 8;
    localparam logic [DIVISOR_W-1:0] DIVISOR_RESET = 8'd4;
    localparam int RESP_TIMEOUT_SD_CLKS = 64;

    localparam int WB_ADDR_W = 3;

    typedef enum logic [WB_ADDR_W-1:0] {
        REG_ARGUMENT      = 3'd0,
        REG_COMMAND       = 3'd1,
        REG_RESPONSE      = 3'd2,
        REG_DIVISOR       = 3'd3,
        REG_INT_STATUS    = 3'd4,
        REG_INT_ENABLE    = 3'd5,
        REG_PRESENT_STATE = 3'd6
    } sd_reg_e;

    // lives in command register bits 7:6
    typedef enum logic [1:0] {
        RESP_NONE  = 2'd0,
        RESP_SHORT = 2'd1
    } sd_resp_e;

    // interrupt status and enable bit positions
    localparam int INT_CMD_COMPLETE = 0;
    localparam int INT_CMD_TIMEOUT = 1;
    localparam int INT_CMD_CRC_ERR = 2;
    localparam int INT_CMD_INDEX_ERR = 3;
    localparam int INT_W = 4;

    // one step of x^7 + x^3 + 1, msb first
    function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic data_bit);
        logic feedback;
        feedback = crc[6] ^ data_bit;
        return {crc[5:0], 1'b0} ^ {3'b000, feedback, 2'b00, feedback};
    endfunction

endpackage
